// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_async_fifo -Mdir obj_dir -f verilog.f
	./obj_dir/Vtb_async_fifo | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: rtl/asym_async_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module asym_async_fifo #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W   = 6
) (
   input  wire                 arst_n_i,

   // write port
   input  wire                 w_clk_i,
   input  wire                 w_en_i,
   input  wire  [W_DATA_W-1:0] w_data_i,
   output logic                w_empty_o,
   output logic                w_full_o,
   output logic [ADDR_W-1:0]   w_level_o,

   // read port
   input  wire                 r_clk_i,
   input  wire                 r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_empty_o,
   output logic                r_full_o,
   output logic [ADDR_W-1:0]   r_level_o,

   fifo_mem_if.ctrl            mem_o
);

   localparam int DIFF     = fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W);
   localparam int W_SHIFT  = (W_DATA_W > R_DATA_W) ? DIFF : 0;
   localparam int R_SHIFT  = (R_DATA_W > W_DATA_W) ? DIFF : 0;
   localparam int W_ADDR_W = ADDR_W - W_SHIFT;
   localparam int R_ADDR_W = ADDR_W - R_SHIFT;

   // sizes in narrow slots
   localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W+1)'(1) << ADDR_W;
   localparam logic [ADDR_W:0] W_INCR    = (ADDR_W+1)'(1) << W_SHIFT;
   localparam logic [ADDR_W:0] R_INCR    = (ADDR_W+1)'(1) << R_SHIFT;

   // local pointers, one extra bit tells full from empty
   logic [W_ADDR_W:0] w_ptr_gray, w_ptr_bin;
   logic [R_ADDR_W:0] r_ptr_gray, r_ptr_bin;

   // pointers seen from the other domain
   logic [W_ADDR_W:0] r_wptr_gray, r_wptr_bin;
   logic [R_ADDR_W:0] w_rptr_gray, w_rptr_bin;

   // everything in narrow slot units
   logic [ADDR_W:0] w_wptr_n, w_rptr_n, r_wptr_n, r_rptr_n;
   logic [ADDR_W:0] w_level_int, r_level_int;

   fifo_pkg::fifo_state_e w_st_q, w_st_d;
   fifo_pkg::fifo_state_e r_st_q, r_st_d;

   logic w_en_int, r_en_int;

   assign w_en_int = w_en_i & ~w_full_o;
   assign r_en_int = r_en_i & ~r_empty_o;

   gray_counter #(.W(W_ADDR_W+1)) w_ptr_cnt (
      .clk_i    (w_clk_i),
      .arst_n_i (arst_n_i),
      .en_i     (w_en_int),
      .gray_o   (w_ptr_gray),
      .bin_o    (w_ptr_bin)
   );

   gray_counter #(.W(R_ADDR_W+1)) r_ptr_cnt (
      .clk_i    (r_clk_i),
      .arst_n_i (arst_n_i),
      .en_i     (r_en_int),
      .gray_o   (r_ptr_gray),
      .bin_o    (r_ptr_bin)
   );

   // write pointer into the read domain
   cdc_sync #(.DATA_W(W_ADDR_W+1), .RST_VAL('0)) w2r_sync (
      .clk_i    (r_clk_i),
      .arst_n_i (arst_n_i),
      .signal_i (w_ptr_gray),
      .signal_o (r_wptr_gray)
   );

   // read pointer into the write domain
   cdc_sync #(.DATA_W(R_ADDR_W+1), .RST_VAL('0)) r2w_sync (
      .clk_i    (w_clk_i),
      .arst_n_i (arst_n_i),
      .signal_i (r_ptr_gray),
      .signal_o (w_rptr_gray)
   );

   assign r_wptr_bin = (W_ADDR_W+1)'(fifo_pkg::gray_to_bin(16'(r_wptr_gray)));
   assign w_rptr_bin = (R_ADDR_W+1)'(fifo_pkg::gray_to_bin(16'(w_rptr_gray)));

   assign w_wptr_n = (ADDR_W+1)'(w_ptr_bin) << W_SHIFT;
   assign w_rptr_n = (ADDR_W+1)'(w_rptr_bin) << R_SHIFT;
   assign r_wptr_n = (ADDR_W+1)'(r_wptr_bin) << W_SHIFT;
   assign r_rptr_n = (ADDR_W+1)'(r_ptr_bin) << R_SHIFT;

   assign w_level_int = w_wptr_n - w_rptr_n;
   assign r_level_int = r_wptr_n - r_rptr_n;

   // a full FIFO wraps to zero here, the full flag tells it apart
   assign w_level_o = w_level_int[ADDR_W-1:0];
   assign r_level_o = r_level_int[ADDR_W-1:0];

   always_ff @(posedge w_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         w_st_q <= fifo_pkg::ST_INIT;
      end else begin
         w_st_q <= w_st_d;
      end
   end

   always_ff @(posedge r_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_st_q <= fifo_pkg::ST_INIT;
      end else begin
         r_st_q <= r_st_d;
      end
   end

   // write FSM, the read side only ever frees space
   always_comb begin
      w_st_d    = w_st_q;
      w_full_o  = 1'b0;
      w_empty_o = 1'b0;
      case (w_st_q)
         fifo_pkg::ST_INIT: begin
            // blocks writes for one clock after reset
            w_full_o  = 1'b1;
            w_empty_o = 1'b1;
            w_st_d    = fifo_pkg::ST_DEFAULT;
         end
         fifo_pkg::ST_FULL: begin
            w_full_o = 1'b1;
            if (w_level_int <= FIFO_SIZE - W_INCR) begin
               w_st_d = fifo_pkg::ST_DEFAULT;
            end
         end
         default: begin
            w_empty_o = (w_level_int == '0);
            // this write would leave no room for another word
            if (w_en_i && (w_level_int + W_INCR > FIFO_SIZE - W_INCR)) begin
               w_st_d = fifo_pkg::ST_FULL;
            end
         end
      endcase
   end

   // read FSM, the write side only ever adds data
   always_comb begin
      r_st_d    = r_st_q;
      r_full_o  = 1'b0;
      r_empty_o = 1'b0;
      case (r_st_q)
         fifo_pkg::ST_INIT: begin
            r_full_o  = 1'b1;
            r_empty_o = 1'b1;
            r_st_d    = fifo_pkg::ST_EMPTY;
         end
         fifo_pkg::ST_EMPTY: begin
            r_empty_o = 1'b1;
            if (r_level_int >= R_INCR) begin
               r_st_d = fifo_pkg::ST_DEFAULT;
            end
         end
         default: begin
            r_full_o = (r_level_int == FIFO_SIZE);
            // less than one read word left after this read
            if (r_en_i && ((r_level_int - R_INCR) < R_INCR)) begin
               r_st_d = fifo_pkg::ST_EMPTY;
            end
         end
      endcase
   end

   assign mem_o.w_en   = w_en_int;
   assign mem_o.w_addr = w_ptr_bin[W_ADDR_W-1:0];
   assign mem_o.w_data = w_data_i;
   assign mem_o.r_en   = r_en_int;
   assign mem_o.r_addr = r_ptr_bin[R_ADDR_W-1:0];
   assign r_data_o     = mem_o.r_data;

   // accepted write always fits, checked against the synced read pointer
   no_write_when_full_a: assert property (
      @(posedge w_clk_i) disable iff (!arst_n_i)
      w_en_int |-> (w_level_int <= FIFO_SIZE - W_INCR)
   ) else $error("write accepted without room for a word");

   // accepted read always finds a whole word written by the other side
   no_read_when_empty_a: assert property (
      @(posedge r_clk_i) disable iff (!arst_n_i)
      r_en_int |-> (r_level_int >= R_INCR)
   ) else $error("read accepted with less than one word stored");

endmodule

`default_nettype wire

// File: rtl/asym_ram_t2p.sv
`timescale 1ns/10ps
`default_nettype none

module asym_ram_t2p #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W   = 6
) (
   input wire       w_clk_i,
   input wire       r_clk_i,
   fifo_mem_if.mem  mem_i
);

   localparam int MIN_W   = fifo_pkg::min_w(W_DATA_W, R_DATA_W);
   localparam int DIFF    = fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W);
   localparam int W_LANES = W_DATA_W / MIN_W;
   localparam int R_LANES = R_DATA_W / MIN_W;

   // lane index bits below the word address on the wide side
   localparam int W_SHIFT = (W_DATA_W > R_DATA_W) ? DIFF : 0;
   localparam int R_SHIFT = (R_DATA_W > W_DATA_W) ? DIFF : 0;

   localparam int DEPTH = 2 ** ADDR_W;

   // narrow slots, one per lane
   logic [MIN_W-1:0]    ram [DEPTH];
   logic [R_DATA_W-1:0] r_data_q;

   // wide write spreads over consecutive slots, lane 0 lowest
   always_ff @(posedge w_clk_i) begin
      if (mem_i.w_en) begin
         for (int i = 0; i < W_LANES; i++) begin
            ram[(ADDR_W'(mem_i.w_addr) << W_SHIFT) | ADDR_W'(i)] <=
               mem_i.w_data[i*MIN_W +: MIN_W];
         end
      end
   end

   // registered read, holds between read strobes
   always_ff @(posedge r_clk_i) begin
      if (mem_i.r_en) begin
         for (int i = 0; i < R_LANES; i++) begin
            r_data_q[i*MIN_W +: MIN_W] <=
               ram[(ADDR_W'(mem_i.r_addr) << R_SHIFT) | ADDR_W'(i)];
         end
      end
   end

   assign mem_i.r_data = r_data_q;

endmodule

`default_nettype wire

// File: rtl/async_fifo_top.sv
`timescale 1ns/10ps
`default_nettype none

module async_fifo_top #(
   parameter int W_DATA_W = fifo_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W
) (
   input  wire                 arst_n_i,

   input  wire                 w_clk_i,
   input  wire                 w_en_i,
   input  wire  [W_DATA_W-1:0] w_data_i,
   output wire                 w_empty_o,
   output wire                 w_full_o,
   output wire  [ADDR_W-1:0]   w_level_o,

   input  wire                 r_clk_i,
   input  wire                 r_en_i,
   output wire  [R_DATA_W-1:0] r_data_o,
   output wire                 r_empty_o,
   output wire                 r_full_o,
   output wire  [ADDR_W-1:0]   r_level_o
);

   // control to RAM bus
   fifo_mem_if #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) mem_bus ();

   asym_async_fifo #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) fifo_core (
      .arst_n_i  (arst_n_i),
      .w_clk_i   (w_clk_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_empty_o (w_empty_o),
      .w_full_o  (w_full_o),
      .w_level_o (w_level_o),
      .r_clk_i   (r_clk_i),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .r_full_o  (r_full_o),
      .r_level_o (r_level_o),
      .mem_o     (mem_bus.ctrl)
   );

   asym_ram_t2p #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) fifo_ram (
      .w_clk_i (w_clk_i),
      .r_clk_i (r_clk_i),
      .mem_i   (mem_bus.mem)
   );

endmodule

`default_nettype wire

// File: rtl/cdc_sync.sv
`timescale 1ns/10ps
`default_nettype none

module cdc_sync #(
   parameter int                DATA_W  = 1,
   parameter logic [DATA_W-1:0] RST_VAL = '0
) (
   input  wire              clk_i,
   input  wire              arst_n_i,
   input  wire [DATA_W-1:0] signal_i,
   output wire [DATA_W-1:0] signal_o
);

   // only Gray-coded buses go through here, one bit moves at a time
   logic [DATA_W-1:0] meta_q;
   logic [DATA_W-1:0] sync_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         meta_q <= RST_VAL;
         sync_q <= RST_VAL;
      end else begin
         // first stage may go metastable
         meta_q <= signal_i;
         sync_q <= meta_q;
      end
   end

   assign signal_o = sync_q;

endmodule

`default_nettype wire

// File: rtl/fifo_mem_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fifo_mem_if #(
   parameter int W_DATA_W = 32,
   parameter int R_DATA_W = 8,
   parameter int ADDR_W   = 6
);

   // the wider port addresses fewer, wider words
   localparam int DIFF     = fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W);
   localparam int W_ADDR_W = (W_DATA_W > R_DATA_W) ? ADDR_W - DIFF : ADDR_W;
   localparam int R_ADDR_W = (R_DATA_W > W_DATA_W) ? ADDR_W - DIFF : ADDR_W;

   // write side, write clock domain
   logic                w_en;
   logic [W_ADDR_W-1:0] w_addr;
   logic [W_DATA_W-1:0] w_data;

   // read side, read clock domain
   logic                r_en;
   logic [R_ADDR_W-1:0] r_addr;
   logic [R_DATA_W-1:0] r_data;

   modport ctrl (
      output w_en, w_addr, w_data,
      output r_en, r_addr,
      input  r_data
   );

   modport mem (
      input  w_en, w_addr, w_data,
      input  r_en, r_addr,
      output r_data
   );

endinterface

`default_nettype wire

// File: rtl/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

   // default build: 32-bit write, 8-bit read, 64 narrow slots
   localparam int DEF_W_DATA_W = 32;
   localparam int DEF_R_DATA_W = 8;
   localparam int DEF_ADDR_W   = 6;

   // flag FSM states, shared by both clock domains
   typedef enum logic [1:0] {
      ST_INIT,
      ST_EMPTY,
      ST_DEFAULT,
      ST_FULL
   } fifo_state_e;

   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // log2 of the wide/narrow ratio, widths are powers of two
   function automatic int ratio_log2(input int a, input int b);
      return $clog2(max_w(a, b) / min_w(a, b));
   endfunction

   // pointers are at most 16 bits wide
   function automatic logic [15:0] gray_to_bin(input logic [15:0] gray);
      logic [15:0] bin;
      bin[15] = gray[15];
      for (int i = 14; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

`default_nettype wire

// File: rtl/gray_counter.sv
`timescale 1ns/10ps
`default_nettype none

module gray_counter #(
   // at most 16, the width of fifo_pkg::gray_to_bin
   parameter int W = 4
) (
   input  wire          clk_i,
   input  wire          arst_n_i,
   input  wire          en_i,
   output wire [W-1:0]  gray_o,
   output wire [W-1:0]  bin_o
);

   logic [W-1:0] bin_q;
   logic [W-1:0] gray_q;
   logic [W-1:0] bin_nxt;

   assign bin_nxt = bin_q + 1'b1;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bin_q  <= '0;
         gray_q <= '0;
      end else if (en_i) begin
         bin_q  <= bin_nxt;
         // gray copy is registered, no glitches reach the synchronizer
         gray_q <= bin_nxt ^ (bin_nxt >> 1);
      end
   end

   assign gray_o = gray_q;
   assign bin_o  = bin_q;

   // every step flips one gray bit and both copies stay in step
   gray_one_step_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      en_i |=> $onehot(gray_q ^ $past(gray_q))
               && (fifo_pkg::gray_to_bin(16'(gray_q)) == 16'(bin_q))
   ) else $error("gray pointer moved by more than one bit");

endmodule

`default_nettype wire

// File: tb/tb_async_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module tb_async_fifo;

   localparam int W_DATA_W = fifo_pkg::DEF_W_DATA_W;
   localparam int R_DATA_W = fifo_pkg::DEF_R_DATA_W;
   localparam int ADDR_W   = fifo_pkg::DEF_ADDR_W;
   localparam int LANES    = W_DATA_W / R_DATA_W;
   localparam int WORDS    = (2 ** ADDR_W) / LANES;
   localparam int TIMEOUT  = 100;

   logic                arst_n_i;
   logic                w_clk_i;
   logic                w_en_i;
   logic [W_DATA_W-1:0] w_data_i;
   logic                w_empty_o;
   logic                w_full_o;
   logic [ADDR_W-1:0]   w_level_o;
   logic                r_clk_i;
   logic                r_en_i;
   logic [R_DATA_W-1:0] r_data_o;
   logic                r_empty_o;
   logic                r_full_o;
   logic [ADDR_W-1:0]   r_level_o;

   // bytes written and not yet read with the oldest first
   logic [R_DATA_W-1:0] model_q[$];
   int                  seed;

   async_fifo_top #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) DUT (
      .arst_n_i  (arst_n_i),
      .w_clk_i   (w_clk_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_empty_o (w_empty_o),
      .w_full_o  (w_full_o),
      .w_level_o (w_level_o),
      .r_clk_i   (r_clk_i),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .r_full_o  (r_full_o),
      .r_level_o (r_level_o)
   );

   initial begin
      w_clk_i = 1'b0;
      forever #50 w_clk_i = ~w_clk_i;
   end

   // read clock lags by 37 ns
   initial begin
      r_clk_i = 1'b0;
      #37;
      forever #50 r_clk_i = ~r_clk_i;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_data(input logic [R_DATA_W-1:0] got, input logic [R_DATA_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         abort_run($sformatf("mismatch at %0t: %s, got %h, expected %h",
                             $time, what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         abort_run($sformatf("mismatch at %0t: %s, got %b, expected %b",
                             $time, what, got, exp));
      end
   endtask

   task automatic check_level(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
                              input string what);
      if (got !== exp) begin
         abort_run($sformatf("mismatch at %0t: %s, got %0d, expected %0d",
                             $time, what, got, exp));
      end
   endtask

   // waits on w_full_o or w_empty_o sampled on falling edges
   task automatic wait_write_flag(input bit use_full, input logic want, input string what);
      int cycles;
      cycles = 0;
      @(negedge w_clk_i);
      while ((use_full ? w_full_o : w_empty_o) !== want) begin
         if (cycles == TIMEOUT) begin
            abort_run($sformatf("timeout at %0t: %s", $time, what));
         end
         cycles++;
         @(negedge w_clk_i);
      end
   endtask

   task automatic wait_read_flag(input bit use_full, input logic want, input string what);
      int cycles;
      cycles = 0;
      @(negedge r_clk_i);
      while ((use_full ? r_full_o : r_empty_o) !== want) begin
         if (cycles == TIMEOUT) begin
            abort_run($sformatf("timeout at %0t: %s", $time, what));
         end
         cycles++;
         @(negedge r_clk_i);
      end
   endtask

   // one write strobe where obey waits for room first
   task automatic write_word(input logic [W_DATA_W-1:0] data, input bit obey);
      int cycles;
      cycles = 0;
      @(negedge w_clk_i);
      while (obey && w_full_o) begin
         if (cycles == TIMEOUT) begin
            abort_run($sformatf("timeout at %0t: write side stayed full", $time));
         end
         cycles++;
         @(negedge w_clk_i);
      end
      w_en_i   = 1'b1;
      w_data_i = data;
      // lowest lane leaves the FIFO first
      if (!w_full_o) begin
         for (int i = 0; i < LANES; i++) begin
            model_q.push_back(data[i*R_DATA_W +: R_DATA_W]);
         end
      end
      @(negedge w_clk_i);
      w_en_i = 1'b0;
   endtask

   // one read strobe with the data checked one clock later
   task automatic read_byte(input bit obey);
      logic [R_DATA_W-1:0] held;
      logic                taken;
      int                  cycles;
      cycles = 0;
      @(negedge r_clk_i);
      while (obey && r_empty_o) begin
         if (cycles == TIMEOUT) begin
            abort_run($sformatf("timeout at %0t: read side stayed empty", $time));
         end
         cycles++;
         @(negedge r_clk_i);
      end
      held   = r_data_o;
      taken  = !r_empty_o;
      r_en_i = 1'b1;
      @(negedge r_clk_i);
      r_en_i = 1'b0;
      if (!taken) begin
         check_data(r_data_o, held, "r_data_o after a read while empty");
      end else if (model_q.size() == 0) begin
         abort_run("a read was accepted although no data was written");
      end else begin
         check_data(r_data_o, model_q.pop_front(), "read data");
      end
   endtask

   task automatic reset_state_test();
      // init state shows full for one clock
      wait_write_flag(1'b1, 1'b0, "write side still full after reset");
      check_flag(w_empty_o, 1'b1, "w_empty_o after reset");
      check_level(w_level_o, '0, "w_level_o after reset");
      wait_read_flag(1'b1, 1'b0, "read side still full after reset");
      check_flag(r_empty_o, 1'b1, "r_empty_o after reset");
      check_level(r_level_o, '0, "r_level_o after reset");
   endtask

   task automatic fill_test();
      for (int i = 0; i < WORDS; i++) begin
         write_word(W_DATA_W'($random(seed)), 1'b1);
      end
      check_flag(w_full_o, 1'b1, "w_full_o after filling");
      // full size wraps to zero in ADDR_W bits
      check_level(w_level_o, ADDR_W'(model_q.size()), "w_level_o when full");
      // dropped and not pushed to the model
      write_word(W_DATA_W'($random(seed)), 1'b0);
      wait_read_flag(1'b1, 1'b1, "read side never saw the FIFO full");
      check_level(r_level_o, ADDR_W'(model_q.size()), "r_level_o when full");
      while (model_q.size() > 0) begin
         read_byte(1'b1);
      end
      check_flag(r_empty_o, 1'b1, "r_empty_o after draining");
      // an accepted extra word would keep the write side from going empty
      wait_write_flag(1'b0, 1'b1, "write side never saw the FIFO empty");
      check_level(w_level_o, '0, "w_level_o after draining");
   endtask

   task automatic lane_order_test();
      write_word(W_DATA_W'(32'h4433_2211), 1'b1);
      write_word(W_DATA_W'($random(seed)), 1'b1);
      write_word(W_DATA_W'($random(seed)), 1'b1);
      for (int i = 0; i < 3 * LANES; i++) begin
         read_byte(1'b1);
      end
      check_flag(r_empty_o, 1'b1, "r_empty_o after lane order reads");
   endtask

   task automatic empty_read_test();
      repeat (3) begin
         read_byte(1'b0);
         check_flag(r_empty_o, 1'b1, "r_empty_o after a read while empty");
      end
      write_word(W_DATA_W'($random(seed)), 1'b1);
      wait_read_flag(1'b0, 1'b0, "r_empty_o did not fall after a write");
      check_level(r_level_o, ADDR_W'(LANES), "r_level_o after one write");
      repeat (LANES) begin
         read_byte(1'b1);
      end
      wait_write_flag(1'b0, 1'b1, "write side did not return to empty");
   endtask

   task automatic mixed_stream_test();
      fork
         begin
            for (int i = 0; i < 40; i++) begin
               repeat ($unsigned($random(seed)) % 4) @(negedge w_clk_i);
               write_word(W_DATA_W'($random(seed)), 1'b1);
            end
         end
         begin
            for (int i = 0; i < 40 * LANES; i++) begin
               repeat ($unsigned($random(seed)) % 3) @(negedge r_clk_i);
               read_byte(1'b1);
            end
         end
      join
      wait_read_flag(1'b0, 1'b1, "read side not empty after the stream");
      check_level(r_level_o, '0, "r_level_o after the stream");
      wait_write_flag(1'b0, 1'b1, "write side not empty after the stream");
      check_level(w_level_o, '0, "w_level_o after the stream");
   endtask

   initial begin
      seed     = 32'h360c;
      arst_n_i = 1'b0;
      w_en_i   = 1'b0;
      w_data_i = '0;
      r_en_i   = 1'b0;
      repeat (16) @(posedge w_clk_i);
      @(negedge w_clk_i);
      arst_n_i = 1'b1;
      reset_state_test();
      fill_test();
      lane_order_test();
      empty_read_test();
      mixed_stream_test();
      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
rtl/fifo_pkg.sv
rtl/fifo_mem_if.sv
rtl/cdc_sync.sv
rtl/gray_counter.sv
rtl/asym_ram_t2p.sv
rtl/asym_async_fifo.sv
rtl/async_fifo_top.sv
tb/tb_async_fifo.sv
